/* dmem_pkg.sv */
// --------------------------------------------------
// Shared widths, MMIO region map and counter type
// The region is 64 bytes and must be 64-byte aligned
// Word index bit 3 picks the block, bits 2:0 the word
// --------------------------------------------------
package dmem_pkg;

    localparam int ADDR_W        = 32;          // Byte address width
    localparam int DATA_W        = 32;          // Bus data width
    localparam int STRB_W        = DATA_W / 8;  // One strobe per byte

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;

    // ------------------------------------------------
    // MMIO region
    localparam int    MMIO_OFFSET_W     = 6;              // 64 byte window
    localparam addr_t DEFAULT_MMIO_BASE = 32'h0001_0000;  // Reset-time default

    typedef logic [2:0] mmio_idx_t;  // Word index inside one block

    // Word offsets from the region base
    localparam logic [MMIO_OFFSET_W-3:0] TIME_LO = 4'd0;   // Timer block
    localparam logic [MMIO_OFFSET_W-3:0] TIME_HI = 4'd1;
    localparam logic [MMIO_OFFSET_W-3:0] TCMP_LO = 4'd2;
    localparam logic [MMIO_OFFSET_W-3:0] TCMP_HI = 4'd3;
    localparam logic [MMIO_OFFSET_W-3:0] CYC_LO  = 4'd8;   // Counter block
    localparam logic [MMIO_OFFSET_W-3:0] CYC_HI  = 4'd9;
    localparam logic [MMIO_OFFSET_W-3:0] IRET_LO = 4'd10;
    localparam logic [MMIO_OFFSET_W-3:0] IRET_HI = 4'd11;
    localparam logic [MMIO_OFFSET_W-3:0] INHIBIT = 4'd12;  // Only writable counter word

    // ------------------------------------------------
    // 64-bit counter, seen whole or as two bus words
    typedef union packed {
        logic [2*DATA_W-1:0] full;  // Count / compare arithmetic
        struct packed {
            data_t hi;              // Upper bus word
            data_t lo;              // Lower bus word
        } half;
    } ctr_word_u;

endpackage

/* dmem_router.sv */
// --------------------------------------------------
// Data bus router: external port or MMIO blocks
// MMIO accesses are granted one cycle after accept
// External accesses pass through with no added delay
// MMIO_BASE_ADDR must be 64-byte aligned
// --------------------------------------------------
module dmem_router import dmem_pkg::*; #(
    parameter addr_t MMIO_BASE_ADDR = DEFAULT_MMIO_BASE
) (
    input  logic      g_clk,
    input  logic      i_arst_n,
    input  logic      i_req,         // Requester side
    input  addr_t     i_addr,
    input  logic      i_wen,
    input  strb_t     i_strb,
    input  data_t     i_wdata,
    output logic      o_gnt,
    output logic      o_err,
    output data_t     o_rdata,
    output logic      o_dmem_req,    // External port
    output addr_t     o_dmem_addr,
    output logic      o_dmem_wen,
    output strb_t     o_dmem_strb,
    output data_t     o_dmem_wdata,
    input  logic      i_dmem_gnt,
    input  logic      i_dmem_err,
    input  data_t     i_dmem_rdata,
    output logic      o_tmr_sel,     // MMIO blocks
    output logic      o_ctr_sel,
    output logic      o_mmio_wen,
    output mmio_idx_t o_mmio_idx,
    output data_t     o_mmio_wdata,
    input  data_t     i_tmr_rdata,
    input  data_t     i_ctr_rdata
);

    logic                     in_region;   // Address hits MMIO window
    logic [MMIO_OFFSET_W-3:0] word_idx;    // Word offset in window
    logic                     mapped;      // Word has a register
    logic                     writable;    // Word accepts writes
    logic                     bad_access;  // Any MMIO legality failure
    logic                     accept;      // MMIO access taken this cycle
    logic                     pending_q;   // Grant due this cycle
    logic                     err_q;       // Registered legality result
    logic                     ctr_q;       // Counter block was chosen

    assign in_region = i_addr[ADDR_W-1:MMIO_OFFSET_W] == MMIO_BASE_ADDR[ADDR_W-1:MMIO_OFFSET_W];
    assign word_idx  = i_addr[MMIO_OFFSET_W-1:2];

    always_comb begin
        mapped   = 1'b0;
        writable = 1'b0;
        case (word_idx)
            TIME_LO, TIME_HI, TCMP_LO, TCMP_HI, INHIBIT: begin
                mapped   = 1'b1;
                writable = 1'b1;
            end
            CYC_LO, CYC_HI, IRET_LO, IRET_HI: begin
                mapped   = 1'b1;                       // Read only
            end
            default: ;
        endcase
    end

    assign bad_access = (i_addr[1:0] != 2'b00)                   // Misaligned
                     || (i_wen && (i_strb != {STRB_W{1'b1}}))    // Partial write
                     || !mapped
                     || (i_wen && !writable);

    // ----------------------------------------------
    // MMIO accept, req ignored while grant is due
    assign accept       = i_req && in_region && !pending_q;
    assign o_tmr_sel    = accept && !bad_access && !word_idx[MMIO_OFFSET_W-3];
    assign o_ctr_sel    = accept && !bad_access &&  word_idx[MMIO_OFFSET_W-3];
    assign o_mmio_wen   = i_wen;
    assign o_mmio_idx   = word_idx[2:0];                 // Index within block
    assign o_mmio_wdata = i_wdata;

    always_ff @(posedge g_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pending_q <= 1'b0;
            err_q     <= 1'b0;
            ctr_q     <= 1'b0;
        end else begin
            pending_q <= accept;                         // Self-clears after grant
            if (accept) begin
                err_q <= bad_access;
                ctr_q <= word_idx[MMIO_OFFSET_W-3];
            end
        end
    end

    // ----------------------------------------------
    // External pass-through and response merge
    assign o_dmem_req   = i_req && !in_region;
    assign o_dmem_addr  = i_addr;
    assign o_dmem_wen   = i_wen;
    assign o_dmem_strb  = i_strb;
    assign o_dmem_wdata = i_wdata;

    assign o_gnt   = pending_q || (o_dmem_req && i_dmem_gnt);
    assign o_err   = pending_q ? err_q : (o_dmem_req && i_dmem_gnt && i_dmem_err);
    assign o_rdata = !pending_q ? i_dmem_rdata :
                     err_q      ? '0           :
                     ctr_q      ? i_ctr_rdata  : i_tmr_rdata;

endmodule

/* timer_regs.sv */
// --------------------------------------------------
// Time counter, compare register, timer interrupt
// Halves are written one word at a time
// A low-half write does not stop the upper half count
// Read word appears the cycle after i_sel
// --------------------------------------------------
module timer_regs import dmem_pkg::*; (
    input  logic      g_clk,
    input  logic      i_arst_n,
    input  logic      i_sel,         // One-cycle access strobe
    input  logic      i_wen,         // Write when selected
    input  mmio_idx_t i_idx,         // Word inside block
    input  data_t     i_wdata,
    input  logic      i_inhibit_tm,  // Freeze the time count
    output data_t     o_rdata,
    output logic      o_timer_irq
);

    ctr_word_u                time_q;   // Running time
    ctr_word_u                tcmp_q;   // Compare value
    data_t                    rdata_q;  // Registered read word
    logic [MMIO_OFFSET_W-3:0] word;     // Region word offset
    logic                     wr;       // Write strobe

    assign word = {1'b0, i_idx};        // Timer block is the lower half
    assign wr   = i_sel && i_wen;

    always_ff @(posedge g_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            time_q.full <= '0;
            tcmp_q.full <= '1;                              // No interrupt out of reset
        end else begin
            if (!i_inhibit_tm) begin
                time_q.full <= time_q.full + 1'b1;
            end
            if (wr) begin
                case (word)                                 // Later write wins over count
                    TIME_LO: time_q.half.lo <= i_wdata;
                    TIME_HI: time_q.half.hi <= i_wdata;
                    TCMP_LO: tcmp_q.half.lo <= i_wdata;
                    TCMP_HI: tcmp_q.half.hi <= i_wdata;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (i_sel) begin
            case (word)
                TIME_LO: rdata_q <= time_q.half.lo;
                TIME_HI: rdata_q <= time_q.half.hi;
                TCMP_LO: rdata_q <= tcmp_q.half.lo;
                TCMP_HI: rdata_q <= tcmp_q.half.hi;
                default: rdata_q <= '0;             // Router never selects these
            endcase
        end
    end

    assign o_rdata     = rdata_q;
    assign o_timer_irq = time_q.full >= tcmp_q.full;  // Straight from registers

endmodule

/* perf_counters.sv */
// --------------------------------------------------
// Cycle and retired-instruction counters, inhibit reg
// Only the inhibit word is writable
// Inhibit bits: 0 cycle, 1 time, 2 retired instr
// Read word appears the cycle after i_sel
// --------------------------------------------------
module perf_counters import dmem_pkg::*; (
    input  logic      g_clk,
    input  logic      i_arst_n,
    input  logic      i_sel,         // One-cycle access strobe
    input  logic      i_wen,         // Write when selected
    input  mmio_idx_t i_idx,         // Word inside block
    input  data_t     i_wdata,
    input  logic      i_instr_ret,   // One pulse per retired instruction
    output data_t     o_rdata,
    output logic      o_inhibit_tm   // To the timer block
);

    localparam int INH_CY = 0;
    localparam int INH_TM = 1;
    localparam int INH_IR = 2;

    ctr_word_u                cycle_q;    // Cycle count
    ctr_word_u                iret_q;     // Retired instruction count
    logic [2:0]               inhibit_q;  // Per-counter freeze
    data_t                    rdata_q;    // Registered read word
    logic [MMIO_OFFSET_W-3:0] word;       // Region word offset

    assign word = {1'b1, i_idx};          // Counter block is the upper half

    // ----------------------------------------------
    // Counters
    always_ff @(posedge g_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cycle_q.full <= '0;
            iret_q.full  <= '0;
        end else begin
            if (!inhibit_q[INH_CY]) begin
                cycle_q.full <= cycle_q.full + 1'b1;
            end
            if (i_instr_ret && !inhibit_q[INH_IR]) begin
                iret_q.full <= iret_q.full + 1'b1;
            end
        end
    end

    always_ff @(posedge g_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            inhibit_q <= '0;
        end else if (i_sel && i_wen && (word == INHIBIT)) begin
            inhibit_q <= i_wdata[2:0];               // Upper bits ignored
        end
    end

    // ----------------------------------------------
    // Read port
    always_ff @(posedge g_clk) begin
        if (i_sel) begin
            case (word)
                CYC_LO:  rdata_q <= cycle_q.half.lo;
                CYC_HI:  rdata_q <= cycle_q.half.hi;
                IRET_LO: rdata_q <= iret_q.half.lo;
                IRET_HI: rdata_q <= iret_q.half.hi;
                INHIBIT: rdata_q <= {{(DATA_W-3){1'b0}}, inhibit_q};
                default: rdata_q <= '0;
            endcase
        end
    end

    assign o_rdata      = rdata_q;
    assign o_inhibit_tm = inhibit_q[INH_TM];

endmodule

/* core_dmem_top.sv */
// --------------------------------------------------
// Data-memory side of the core top level
// Requester holds req and fields steady until gnt
// MMIO_BASE_ADDR must be 64-byte aligned
// --------------------------------------------------
module core_dmem_top import dmem_pkg::*; #(
    parameter addr_t MMIO_BASE_ADDR = DEFAULT_MMIO_BASE
) (
    input  logic  g_clk,
    input  logic  i_arst_n,
    input  logic  i_instr_ret,   // Retire pulse
    input  logic  i_req,         // Requester bus
    input  addr_t i_addr,
    input  logic  i_wen,
    input  strb_t i_strb,
    input  data_t i_wdata,
    output logic  o_gnt,
    output logic  o_err,
    output data_t o_rdata,
    output logic  o_dmem_req,    // External data port
    output addr_t o_dmem_addr,
    output logic  o_dmem_wen,
    output strb_t o_dmem_strb,
    output data_t o_dmem_wdata,
    input  logic  i_dmem_gnt,
    input  logic  i_dmem_err,
    input  data_t i_dmem_rdata,
    output logic  o_timer_irq
);

    logic      tmr_sel;      // Timer block strobe
    logic      ctr_sel;      // Counter block strobe
    logic      mmio_wen;
    mmio_idx_t mmio_idx;
    data_t     mmio_wdata;
    data_t     tmr_rdata;
    data_t     ctr_rdata;
    logic      inhibit_tm;   // Counter block freezes time

    dmem_router #(.MMIO_BASE_ADDR(MMIO_BASE_ADDR)) u_router (
        .g_clk, .i_arst_n, .i_req, .i_addr, .i_wen, .i_strb, .i_wdata,
        .o_gnt, .o_err, .o_rdata,
        .o_dmem_req, .o_dmem_addr, .o_dmem_wen, .o_dmem_strb, .o_dmem_wdata,
        .i_dmem_gnt, .i_dmem_err, .i_dmem_rdata,
        .o_tmr_sel    (tmr_sel),
        .o_ctr_sel    (ctr_sel),
        .o_mmio_wen   (mmio_wen),
        .o_mmio_idx   (mmio_idx),
        .o_mmio_wdata (mmio_wdata),
        .i_tmr_rdata  (tmr_rdata),
        .i_ctr_rdata  (ctr_rdata)
    );

    timer_regs u_timer (
        .g_clk, .i_arst_n,
        .i_sel (tmr_sel), .i_wen (mmio_wen), .i_idx (mmio_idx), .i_wdata (mmio_wdata),
        .i_inhibit_tm (inhibit_tm),
        .o_rdata      (tmr_rdata),
        .o_timer_irq
    );

    perf_counters u_counters (
        .g_clk, .i_arst_n,
        .i_sel (ctr_sel), .i_wen (mmio_wen), .i_idx (mmio_idx), .i_wdata (mmio_wdata),
        .i_instr_ret,
        .o_rdata      (ctr_rdata),
        .o_inhibit_tm (inhibit_tm)
    );

endmodule

/* core_dmem_asserts.sv */
// --------------------------------------------------
// Handshake assertions, bound into dmem_router
// Region base follows the router parameter
// Requester must hold req until gnt
// --------------------------------------------------
module core_dmem_asserts import dmem_pkg::*; #(
    parameter addr_t MMIO_BASE_ADDR = DEFAULT_MMIO_BASE
) (
    input logic  g_clk,
    input logic  i_arst_n,
    input logic  i_req,
    input addr_t i_addr,
    input logic  o_gnt,
    input logic  o_dmem_req
);
    timeunit 1ns;
    timeprecision 100ps;

    logic region;                // Address inside MMIO window
    logic open_q;                // Request seen, not yet granted
    logic start;                 // First cycle of a region access
    logic mmio_gnt;              // Grant of a region access

    assign region   = i_addr[ADDR_W-1:MMIO_OFFSET_W] == MMIO_BASE_ADDR[ADDR_W-1:MMIO_OFFSET_W];
    assign start    = i_req && region && !open_q;
    assign mmio_gnt = o_gnt && i_req && region;

    always_ff @(posedge g_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            open_q <= 1'b0;
        end else begin
            open_q <= i_req && !o_gnt;   // Clears after the grant cycle
        end
    end

    // --------------------------------------------
    no_ext_req_in_region: assert property (@(posedge g_clk) disable iff (!i_arst_n)
        region |-> !o_dmem_req)
        else $error("external request raised for a region address");

    gnt_after_start: assert property (@(posedge g_clk) disable iff (!i_arst_n)
        start |=> o_gnt)
        else $error("MMIO grant missing one cycle after request start");

    gnt_needs_start: assert property (@(posedge g_clk) disable iff (!i_arst_n)
        mmio_gnt |-> $past(start))
        else $error("MMIO grant without request start in the previous cycle");

    no_back_to_back_gnt: assert property (@(posedge g_clk) disable iff (!i_arst_n)
        mmio_gnt |=> !mmio_gnt)
        else $error("MMIO grant high in two consecutive cycles");

endmodule

bind dmem_router core_dmem_asserts #(.MMIO_BASE_ADDR(MMIO_BASE_ADDR)) u_asserts (
    .g_clk      (g_clk),
    .i_arst_n   (i_arst_n),
    .i_req      (i_req),
    .i_addr     (i_addr),
    .o_gnt      (o_gnt),
    .o_dmem_req (o_dmem_req)
);

/* core_dmem_tb.sv */
// --------------------------------------------------
// Testbench for core_dmem_top, plays core_dmem_stim.txt
// Run from the project root so the data file is found
// External memory answers addr ^ RDATA_KEY, errs at ERR_ADDR
// --------------------------------------------------
module core_dmem_tb import dmem_pkg::*;;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          CLK_PERIOD  = 4;
    localparam int          RST_CYCLES  = 10;
    localparam int          LINE_CYCLES = 20;              // Watchdog budget per line
    localparam int          NCOL        = 7;               // Columns per stimulus line
    localparam addr_t       MMIO_BASE   = DEFAULT_MMIO_BASE;
    localparam data_t       RDATA_KEY   = 32'h5a5a_0ff0;   // External read data mask
    localparam addr_t       ERR_ADDR    = 32'h0000_2000;   // External model errs here
    localparam int unsigned SEED        = 32'haabf_901f;

    logic  g_clk = 1'b0;
    logic  i_arst_n, i_instr_ret;
    logic  i_req, i_wen, o_gnt, o_err;
    addr_t i_addr;
    strb_t i_strb;
    data_t i_wdata, o_rdata;
    logic  o_dmem_req, o_dmem_wen, i_dmem_gnt, i_dmem_err, o_timer_irq;
    addr_t o_dmem_addr;
    strb_t o_dmem_strb;
    data_t o_dmem_wdata, i_dmem_rdata;

    data_t stim_q[$];            // Flat, NCOL words per line
    int    n_lines;
    data_t last_rdata;           // Base for relative reads
    logic  model_busy;
    int    model_wait;           // Cycles left before external gnt

    core_dmem_top #(.MMIO_BASE_ADDR(MMIO_BASE)) DUT (.*);

    always #(CLK_PERIOD/2) g_clk = ~g_clk;

    // --------------------------------------------
    task automatic check(input data_t actual, input data_t expected, input string what);
        if (actual !== expected) begin
            $display("FAILED at %0d ns: %s, got %h expected %h", $time, what, actual, expected);
            $display("Some tests failed");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("Run aborted: %s", why);
        $display("Some tests failed");
        $fatal(1, "Run aborted");
    endtask

    function automatic logic is_mmio(input addr_t a);
        return a[ADDR_W-1:MMIO_OFFSET_W] == MMIO_BASE[ADDR_W-1:MMIO_OFFSET_W];
    endfunction

    task automatic read_stim_file();
        int    fd;
        int    got;
        string line;
        data_t col[NCOL];
        fd = $fopen("core_dmem_stim.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open core_dmem_stim.txt");
        end else begin
            while (!$feof(fd)) begin
                got = $fgets(line, fd);                    // Comment lines scan as zero fields
                if (got > 0 && $sscanf(line, "%h %h %h %h %h %h %h", col[0], col[1],
                                       col[2], col[3], col[4], col[5], col[6]) == NCOL) begin
                    foreach (col[k]) begin
                        stim_q.push_back(col[k]);
                    end
                end
            end
            $fclose(fd);
            n_lines = stim_q.size() / NCOL;
        end
    endtask

    // One bus access, holds req until gnt
    task automatic bus_access(input logic wen, input addr_t addr, input strb_t strb,
                              input data_t wdata, output data_t rdata, output logic err);
        int   cycles;
        logic mmio;
        mmio   = is_mmio(addr);
        cycles = 0;
        @(posedge g_clk);
        i_req   <= 1'b1;
        i_addr  <= addr;
        i_wen   <= wen;
        i_strb  <= strb;
        i_wdata <= wdata;
        do begin
            @(negedge g_clk);                              // Mid-cycle sample
            cycles++;
            if (mmio) begin
                check(32'(o_dmem_req), 32'h0, "external request for region address");
            end
        end while (!o_gnt);
        rdata = o_rdata;
        err   = o_err;
        if (mmio) begin
            check(32'(cycles), 32'd2, "MMIO grant not one cycle after req");
        end
        @(posedge g_clk);
        i_req <= 1'b0;
    endtask

    task automatic retire_burst(input data_t count);
        repeat (count) begin
            @(posedge g_clk);
            i_instr_ret <= 1'b1;
        end
        @(posedge g_clk);
        i_instr_ret <= 1'b0;
    endtask

    // Kinds: 0 exact read, 1 err only, 2 last read plus delta, 3 retire burst, 4 irq level
    task automatic play_line(input int idx);
        data_t kind, wen, addr, strb;
        data_t wdata, expv, experr, rdata;
        logic  err;
        string tag;
        kind   = stim_q[idx*NCOL];
        wen    = stim_q[idx*NCOL+1];
        addr   = stim_q[idx*NCOL+2];
        strb   = stim_q[idx*NCOL+3];
        wdata  = stim_q[idx*NCOL+4];
        expv   = stim_q[idx*NCOL+5];
        experr = stim_q[idx*NCOL+6];
        tag    = $sformatf("stim line %0d", idx + 1);
        case (kind)
            0, 1, 2: begin
                bus_access(wen[0], addr, strb[STRB_W-1:0], wdata, rdata, err);
                check(32'(err), experr, {tag, " err"});
                if (kind == 0) begin
                    check(rdata, expv, {tag, " rdata"});
                end else if (kind == 2) begin
                    check(rdata, last_rdata + expv, {tag, " rdata delta"});
                end
                last_rdata = rdata;
            end
            3: retire_burst(wdata);
            4: begin
                @(posedge g_clk);
                @(negedge g_clk);
                check(32'(o_timer_irq), expv, {tag, " timer irq"});
            end
            default: abort_run($sformatf("%s has unknown kind %0h", tag, kind));
        endcase
    endtask

    // --------------------------------------------
    // External memory model, random 0-5 cycle grant delay
    initial begin
        void'($urandom(SEED));
        i_dmem_gnt   <= 1'b0;
        i_dmem_err   <= 1'b0;
        i_dmem_rdata <= '0;
        model_busy = 1'b0;
        model_wait = 0;
        forever begin
            @(posedge g_clk);
            if (!i_arst_n || i_dmem_gnt) begin             // Grant lasts one cycle
                i_dmem_gnt <= 1'b0;
                i_dmem_err <= 1'b0;
                model_busy = 1'b0;
            end else if (o_dmem_req) begin
                if (!model_busy) begin
                    model_busy = 1'b1;
                    model_wait = $urandom_range(5, 0);
                end
                if (model_wait == 0) begin
                    check(o_dmem_addr, i_addr, "external addr");
                    check(32'(o_dmem_wen), 32'(i_wen), "external wen");
                    check(32'(o_dmem_strb), 32'(i_strb), "external strb");
                    check(o_dmem_wdata, i_wdata, "external wdata");
                    i_dmem_gnt   <= 1'b1;
                    i_dmem_err   <= (o_dmem_addr == ERR_ADDR);
                    i_dmem_rdata <= o_dmem_addr ^ RDATA_KEY;
                end else begin
                    model_wait--;
                end
            end
        end
    end

    initial begin
        i_arst_n    <= 1'b0;
        i_instr_ret <= 1'b0;
        i_req       <= 1'b0;
        i_addr      <= '0;
        i_wen       <= 1'b0;
        i_strb      <= '0;
        i_wdata     <= '0;
        last_rdata = '0;
        read_stim_file();
        if (n_lines == 0) begin
            abort_run("stimulus file holds no lines");
        end else begin
            repeat (RST_CYCLES) @(posedge g_clk);
            i_arst_n <= 1'b1;
            @(negedge g_clk);
            check(32'(o_gnt), 32'h0, "o_gnt after reset");
            check(32'(o_err), 32'h0, "o_err after reset");
            check(32'(o_dmem_req), 32'h0, "o_dmem_req after reset");
            check(32'(o_timer_irq), 32'h0, "o_timer_irq after reset");
            for (int i = 0; i < n_lines; i++) begin
                play_line(i);
            end
            $display("All tests passed");
            $finish;
        end
    end

    // Watchdog, budget grows with the stimulus length
    initial begin
        wait (n_lines > 0);
        repeat (RST_CYCLES + LINE_CYCLES * n_lines) @(posedge g_clk);
        abort_run($sformatf("timeout, %0d stimulus lines not done in %0d cycles",
                            n_lines, RST_CYCLES + LINE_CYCLES * n_lines));
    end

endmodule

/* project.f */
dmem_pkg.sv
dmem_router.sv
timer_regs.sv
perf_counters.sv
core_dmem_top.sv
core_dmem_asserts.sv
core_dmem_tb.sv

/* Makefile */
# Verilator flow for the data-memory top level
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR  ?= verilator
TOP        ?= core_dmem_tb
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --timing --assert
LINT_FLAGS ?= -Wall
FAIL_MSG   ?= Some tests failed
PASS_MSG   ?= All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "No result in $(LOG)"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* core_dmem_stim.txt */
# kind wen addr strb wdata exp err, all hex; burst count in wdata, irq level in exp
# kind 0 read check, 1 err only, 2 read = last read + exp, 3 retire burst, 4 irq
0 0 00001000 f 00000000 5a5a1ff0 0
0 1 00001004 5 cafe0001 5a5a1ff4 0
0 0 00002000 f 00000000 5a5a2ff0 1
0 1 00010040 f 12345678 5a5b0fb0 0
0 0 0000ffc0 f 00000000 5a5af030 0
1 0 00010002 f 00000000 00000000 1
1 1 00010000 3 00000001 00000000 1
1 0 00010014 f 00000000 00000000 1
1 1 00010020 f 00000001 00000000 1
1 1 00010030 f 00000002 00000000 0
1 1 00010000 f 00000005 00000000 0
1 1 00010004 f 000000ab 00000000 0
1 1 00010008 f 00000006 00000000 0
1 1 0001000c f 000000cd 00000000 0
0 0 00010000 f 00000000 00000005 0
0 0 00010004 f 00000000 000000ab 0
0 0 00010008 f 00000000 00000006 0
0 0 0001000c f 00000000 000000cd 0
1 1 00010004 f 00000000 00000000 0
1 1 0001000c f 00000000 00000000 0
4 0 00000000 0 00000000 00000000 0
1 1 00010008 f 00000005 00000000 0
4 0 00000000 0 00000000 00000001 0
1 1 00010030 f 00000007 00000000 0
1 0 00010020 f 00000000 00000000 0
3 0 00000000 0 00000003 00000000 0
2 0 00010020 f 00000000 00000000 0
0 0 00010028 f 00000000 00000000 0
1 1 00010030 f 00000003 00000000 0
0 0 00010030 f 00000000 00000003 0
0 0 00010028 f 00000000 00000000 0
3 0 00000000 0 00000009 00000000 0
2 0 00010028 f 00000000 00000009 0
